/* psr_consts.svh */
`ifndef PSR_CONSTS_SVH
`define PSR_CONSTS_SVH

// Status word width in bits
`define PSR_WIDTH 32

// Saved status registers: svc, abort, undef, irq, fiq
`define SPSR_BANKS 5

// Exception lines into the unit
`define EXC_COUNT 6

// Control byte out of reset
// IRQ and FIQ masked, ARM state, supervisor mode
`define PSR_RESET_CTRL 8'hD3

`endif

/* psrPkg.sv */
package psrPkg;

  // Processor modes, ARM encodings
  typedef enum logic [4:0] {
    modeUser   = 5'b10000,
    modeFiq    = 5'b10001,
    modeIrq    = 5'b10010,
    modeSvc    = 5'b10011,
    modeAbort  = 5'b10111,
    modeUndef  = 5'b11011,
    modeSystem = 5'b11111
  } cpuMode;

  // Status word, MSB first
  typedef struct packed {
    logic [3:0]  flags;    // N Z C V
    logic [19:0] reserved; // Always written as zero on exception entry
    logic        irqMask;  // I bit
    logic        fiqMask;  // F bit
    logic        thumb;    // T bit
    cpuMode      mode;
  } psrWord;

  // True for the seven defined mode codes
  function automatic logic isLegalMode(input logic [4:0] code);
    case (code)
      modeUser, modeFiq, modeIrq, modeSvc,
      modeAbort, modeUndef, modeSystem: isLegalMode = 1'b1;
      default:                          isLegalMode = 1'b0;
    endcase
  endfunction

endpackage

/* psrReqPkg.sv */
package psrReqPkg;

  // Exception request lines, same order as the core's bus
  typedef struct packed {
    logic undef;
    logic swi;
    logic prefetchAbort;
    logic dataAbort;
    logic irq;
    logic fiq;
  } excLines;

  // Which exception won arbitration
  typedef enum logic [2:0] {
    excNone,
    excDataAbort,
    excFiq,
    excIrq,
    excPrefetch,
    excUndef,
    excSwi
  } excKind;

  // MSR request from writeback
  typedef struct packed {
    logic [3:0] fieldMask; // [3] flags, [2] status, [1] extension, [0] control
    logic       toSpsr;    // Target the current mode's SPSR
  } msrRequest;

endpackage

/* exceptPriority.sv */
`timescale 1ns/1ps
`include "psr_consts.svh"

module exceptPriority (
  input  psrReqPkg::excLines exceptions,
  input  psrPkg::cpuMode     curMode,
  output logic               excTake,
  output psrReqPkg::excKind  excKind,
  output psrPkg::cpuMode     targetMode
);

  // Lines whose target differs from the current mode, highest priority on top
  logic [`EXC_COUNT-1:0] eligible;

  assign eligible = {
    exceptions.dataAbort     & (curMode != psrPkg::modeAbort),
    exceptions.fiq           & (curMode != psrPkg::modeFiq),
    exceptions.irq           & (curMode != psrPkg::modeIrq),
    exceptions.prefetchAbort & (curMode != psrPkg::modeAbort),
    exceptions.undef         & (curMode != psrPkg::modeUndef),
    exceptions.swi           & (curMode != psrPkg::modeSvc)
  };

  assign excTake = |eligible; // A held line is taken once, then masked by mode

  // Fixed priority pick
  always_comb begin
    if (eligible[5])      excKind = psrReqPkg::excDataAbort;
    else if (eligible[4]) excKind = psrReqPkg::excFiq;
    else if (eligible[3]) excKind = psrReqPkg::excIrq;
    else if (eligible[2]) excKind = psrReqPkg::excPrefetch;
    else if (eligible[1]) excKind = psrReqPkg::excUndef;
    else if (eligible[0]) excKind = psrReqPkg::excSwi;
    else                  excKind = psrReqPkg::excNone;
  end

  // Kind to mode
  always_comb begin
    case (excKind)
      psrReqPkg::excDataAbort,
      psrReqPkg::excPrefetch: targetMode = psrPkg::modeAbort; // Both aborts share a bank
      psrReqPkg::excFiq:      targetMode = psrPkg::modeFiq;
      psrReqPkg::excIrq:      targetMode = psrPkg::modeIrq;
      psrReqPkg::excUndef:    targetMode = psrPkg::modeUndef;
      psrReqPkg::excSwi:      targetMode = psrPkg::modeSvc;
      default:                targetMode = curMode;           // No entry, stay put
    endcase
  end

endmodule

/* msrMerge.sv */
`timescale 1ns/1ps
`include "psr_consts.svh"

module msrMerge (
  input  psrReqPkg::msrRequest  msrReq,
  input  logic [`PSR_WIDTH-1:0] aluOut,
  input  psrPkg::psrWord        cpsr,
  input  psrPkg::psrWord        spsrCur,
  input  logic                  hasSpsr,
  output logic                  msrWriteCpsr,
  output logic                  msrWriteSpsr,
  output psrPkg::psrWord        msrValue
);

  logic [`PSR_WIDTH-1:0] target;  // Word being edited
  logic [`PSR_WIDTH-1:0] merged;
  logic                  privileged;
  logic                  anyField;

  assign target     = msrReq.toSpsr ? spsrCur : cpsr;
  assign privileged = (cpsr.mode != psrPkg::modeUser); // Privilege from CPSR even for SPSR writes
  assign anyField   = |msrReq.fieldMask;

  always_comb begin
    merged = target;
    // One byte per field bit
    for (int f = 0; f < 4; f++) begin
      if (msrReq.fieldMask[f] && (f == 3 || privileged)) begin
        merged[f*8 +: 8] = aluOut[f*8 +: 8];
      end
    end
    // Bad mode code keeps the old mode
    // I, F and T still come from aluOut
    if (msrReq.fieldMask[0] && privileged && !psrPkg::isLegalMode(aluOut[4:0])) begin
      merged[4:0] = target[4:0];
    end
  end

  assign msrValue = merged;

  assign msrWriteCpsr = anyField & ~msrReq.toSpsr;
  assign msrWriteSpsr = anyField & msrReq.toSpsr & hasSpsr; // Dropped in user and system

endmodule

/* spsrBank.sv */
`timescale 1ns/1ps
`include "psr_consts.svh"

module spsrBank (
  input  logic           clk,
  input  logic           reset,
  input  psrPkg::cpuMode curMode,
  input  logic           wrEn,
  input  psrPkg::cpuMode wrMode,
  input  psrPkg::psrWord wrData,
  output psrPkg::psrWord rdData,
  output logic           hasSpsr
);

  localparam int idxWidth = $clog2(`SPSR_BANKS);

  // Returns {valid, index}; user and system have no bank
  function automatic logic [idxWidth:0] bankOf(input psrPkg::cpuMode mode);
    case (mode)
      psrPkg::modeSvc:   bankOf = {1'b1, idxWidth'(0)};
      psrPkg::modeAbort: bankOf = {1'b1, idxWidth'(1)};
      psrPkg::modeUndef: bankOf = {1'b1, idxWidth'(2)};
      psrPkg::modeIrq:   bankOf = {1'b1, idxWidth'(3)};
      psrPkg::modeFiq:   bankOf = {1'b1, idxWidth'(4)};
      default:           bankOf = '0;
    endcase
  endfunction

  psrPkg::psrWord        bank [`SPSR_BANKS];
  logic [idxWidth-1:0]   rdIdx;
  logic [idxWidth-1:0]   wrIdx;
  logic                  wrValid;

  assign {hasSpsr, rdIdx} = bankOf(curMode);
  assign {wrValid, wrIdx} = bankOf(wrMode);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `SPSR_BANKS; i++) begin
        bank[i] <= '0;
      end
    end else if (wrEn && wrValid) begin
      bank[wrIdx] <= wrData;
    end
  end

  assign rdData = bank[rdIdx]; // Meaningless when hasSpsr is low
endmodule

/* psrControl.sv */
`timescale 1ns/1ps
`include "psr_consts.svh"

module psrControl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  advance,
  input  logic [3:0]            flagsNext,
  input  logic                  coprocFlagUpd,
  input  logic [`PSR_WIDTH-1:0] aluOut,
  input  logic                  restore,
  input  logic                  excTake,
  input  psrPkg::cpuMode        targetMode,
  input  logic                  msrWriteCpsr,
  input  logic                  msrWriteSpsr,
  input  psrPkg::psrWord        msrValue,
  input  psrPkg::psrWord        spsrCur,
  input  logic                  hasSpsr,
  output psrPkg::psrWord        cpsr,
  output logic                  spsrWrEn,
  output psrPkg::cpuMode        spsrWrMode,
  output psrPkg::psrWord        spsrWrData
);

  logic [3:0]     selFlags;  // Flag unit or coprocessor result
  logic           spsrWrReq;
  psrPkg::psrWord cpsrNext;

  assign selFlags = coprocFlagUpd ? aluOut[`PSR_WIDTH-1 -: 4] : flagsNext;

  // Update priority, first match wins
  always_comb begin
    cpsrNext   = cpsr;
    spsrWrReq  = 1'b0;
    spsrWrMode = cpsr.mode; // MSR to SPSR targets the current bank
    spsrWrData = msrValue;
    if (excTake) begin
      spsrWrReq        = 1'b1;
      spsrWrMode       = targetMode;
      spsrWrData       = cpsr;
      spsrWrData.flags = selFlags;    // Saved word carries this cycle's flags
      cpsrNext.flags    = selFlags;
      cpsrNext.reserved = '0;
      cpsrNext.irqMask  = 1'b1;       // FIQ mask left alone
      cpsrNext.thumb    = 1'b0;       // Handlers run in ARM state
      cpsrNext.mode     = targetMode;
    end else if (msrWriteCpsr) begin
      cpsrNext = msrValue;
    end else if (msrWriteSpsr) begin
      spsrWrReq = 1'b1;
    end else if (restore && hasSpsr) begin
      cpsrNext = spsrCur;             // Return from handler
    end else begin
      cpsrNext.flags = selFlags;
    end
  end

  assign spsrWrEn = advance & spsrWrReq; // Stall holds the bank too

  always_ff @(posedge clk) begin
    if (reset) begin
      cpsr <= {{(`PSR_WIDTH-8){1'b0}}, `PSR_RESET_CTRL};
    end else if (advance) begin
      cpsr <= cpsrNext;
    end
  end

endmodule

/* psrUnit.sv */
`timescale 1ns/1ps
`include "psr_consts.svh"

module psrUnit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  advance,
  input  logic [3:0]            flagsNext,
  input  logic                  coprocFlagUpd,
  input  logic [`PSR_WIDTH-1:0] aluOut,
  input  psrReqPkg::msrRequest  msrReq,
  input  psrReqPkg::excLines    exceptions,
  input  logic                  restore,
  output psrPkg::psrWord        cpsr,
  output psrPkg::psrWord        spsr
);

  logic           excTake;
  psrPkg::cpuMode targetMode;
  logic           msrWriteCpsr;
  logic           msrWriteSpsr;
  psrPkg::psrWord msrValue;
  psrPkg::psrWord spsrCur;   // Current mode's bank
  logic           hasSpsr;
  logic           spsrWrEn;
  psrPkg::cpuMode spsrWrMode;
  psrPkg::psrWord spsrWrData;

  exceptPriority uExcept (
    .exceptions (exceptions),
    .curMode    (cpsr.mode),
    .excTake    (excTake),
    .excKind    (),           // Kind only for waveform debug
    .targetMode (targetMode)
  );

  msrMerge uMsr (
    .msrReq       (msrReq),
    .aluOut       (aluOut),
    .cpsr         (cpsr),
    .spsrCur      (spsrCur),
    .hasSpsr      (hasSpsr),
    .msrWriteCpsr (msrWriteCpsr),
    .msrWriteSpsr (msrWriteSpsr),
    .msrValue     (msrValue)
  );

  spsrBank uBank (
    .clk     (clk),
    .reset   (reset),
    .curMode (cpsr.mode),
    .wrEn    (spsrWrEn),
    .wrMode  (spsrWrMode),
    .wrData  (spsrWrData),
    .rdData  (spsrCur),
    .hasSpsr (hasSpsr)
  );

  psrControl uCtrl (
    .clk           (clk),
    .reset         (reset),
    .advance       (advance),
    .flagsNext     (flagsNext),
    .coprocFlagUpd (coprocFlagUpd),
    .aluOut        (aluOut),
    .restore       (restore),
    .excTake       (excTake),
    .targetMode    (targetMode),
    .msrWriteCpsr  (msrWriteCpsr),
    .msrWriteSpsr  (msrWriteSpsr),
    .msrValue      (msrValue),
    .spsrCur       (spsrCur),
    .hasSpsr       (hasSpsr),
    .cpsr          (cpsr),
    .spsrWrEn      (spsrWrEn),
    .spsrWrMode    (spsrWrMode),
    .spsrWrData    (spsrWrData)
  );

  // User and system show the CPSR
  assign spsr = hasSpsr ? spsrCur : cpsr;

endmodule

/* psrUnit_sva.sv */
`timescale 1ns/1ps

module psrUnitSva (
  input logic           clk,
  input logic           reset,
  input logic           advance,
  input psrPkg::psrWord cpsr,
  input psrPkg::psrWord spsr
);

  int failCount = 0; // Failed assertion count

  // Supervisor mode straight out of reset
  resetToSvc: assert property (@(posedge clk) reset |=> cpsr.mode == psrPkg::modeSvc)
    else begin
      failCount++;
      $error("cpsr mode is not svc after reset");
    end

  legalMode: assert property (@(posedge clk) disable iff (reset)
    cpsr.mode inside {psrPkg::modeUser, psrPkg::modeFiq, psrPkg::modeIrq, psrPkg::modeSvc,
                      psrPkg::modeAbort, psrPkg::modeUndef, psrPkg::modeSystem})
    else begin
      failCount++;
      $error("cpsr holds an undefined mode code");
    end

  // Stalled edge holds CPSR and the banks
  holdOnStall: assert property (@(posedge clk) disable iff (reset)
    !advance |=> ($stable(cpsr) && $stable(spsr)))
    else begin
      failCount++;
      $error("status words changed while advance was low");
    end

endmodule

bind psrUnit psrUnitSva uSva (
  .clk     (clk),
  .reset   (reset),
  .advance (advance),
  .cpsr    (cpsr),
  .spsr    (spsr)
);

/* psrUnit_tb.sv */
`timescale 1ns/1ps
`include "psr_consts.svh"

module psrUnit_tb;

  localparam int testCycles = 5 + 12 + 4 + 7 + 4 + 2; // Reset edges plus every driven edge
  localparam int cycleLimit = 2 * testCycles;

  logic                  clk;
  logic                  reset;
  logic                  advance;
  logic [3:0]            flagsNext;
  logic                  coprocFlagUpd;
  logic [`PSR_WIDTH-1:0] aluOut;
  psrReqPkg::msrRequest  msrReq;
  psrReqPkg::excLines    exceptions;
  logic                  restore;
  psrPkg::psrWord        cpsr;
  psrPkg::psrWord        spsr;

  psrPkg::psrWord expCpsr; // Expected CPSR, kept from the update rules
  logic [15:0]    lfsr;
  int             errors;
  int             checks;
  int             cycles;

  psrUnit u_dut (
    .clk           (clk),
    .reset         (reset),
    .advance       (advance),
    .flagsNext     (flagsNext),
    .coprocFlagUpd (coprocFlagUpd),
    .aluOut        (aluOut),
    .msrReq        (msrReq),
    .exceptions    (exceptions),
    .restore       (restore),
    .cpsr          (cpsr),
    .spsr          (spsr)
  );

  always #5 clk = ~clk; // 10 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: run went past the limit of %0d cycles", cycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr); // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Word after exception entry
  function automatic psrPkg::psrWord entryWord(input psrPkg::psrWord old,
                                               input logic [3:0] f,
                                               input psrPkg::cpuMode m);
    psrPkg::psrWord w;
    w         = '0;       // Reserved bits cleared
    w.flags   = f;
    w.irqMask = 1'b1;
    w.fiqMask = old.fiqMask;
    w.mode    = m;        // Thumb stays clear
    return w;
  endfunction

  // Drive on the falling edge, return on the next falling edge
  task automatic drive(input logic adv, input logic [3:0] flg, input logic cop,
                       input logic [31:0] alu, input logic [4:0] msr,
                       input logic [5:0] exc, input logic rst);
    advance       = adv;
    flagsNext     = flg;
    coprocFlagUpd = cop;
    aluOut        = alu;
    msrReq        = msr; // {fieldMask, toSpsr}
    exceptions    = exc; // undef swi prefetchAbort dataAbort irq fiq
    restore       = rst;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic checkWord(input string test, input string what,
                           input psrPkg::psrWord exp, input psrPkg::psrWord act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic testReset();
    expCpsr = {{(`PSR_WIDTH-8){1'b0}}, `PSR_RESET_CTRL};
    checkWord("reset", "cpsr", expCpsr, cpsr);
    checkWord("reset", "spsr", '0, spsr); // Svc bank cleared
  endtask

  task automatic testFlags();
    logic [31:0] r;
    logic [31:0] a;
    int          i;
    for (i = 0; i < 4; i++) begin
      r = randBits(4);
      drive(1'b1, r[3:0], 1'b0, 32'h0, 5'h0, 6'h0, 1'b0);
      expCpsr.flags = r[3:0];
      checkWord("flags", "cpsr from flag unit", expCpsr, cpsr);
      a = randBits(32);
      drive(1'b1, ~r[3:0], 1'b1, a, 5'h0, 6'h0, 1'b0); // Coprocessor source wins
      expCpsr.flags = a[31:28];
      checkWord("flags", "cpsr from coprocessor", expCpsr, cpsr);
      // Stall with requests up
      // Odd passes raise every line, even passes aim an MSR at the svc bank
      drive(1'b0, ~a[31:28], 1'b1, ~a, {4'b1111, ~i[0]}, i[0] ? 6'h3F : 6'h10, 1'b1);
      checkWord("flags", "cpsr on stall", expCpsr, cpsr);
      checkWord("flags", "spsr on stall", '0, spsr);
    end
  endtask

  task automatic testMsrCpsr();
    logic [31:0] a;
    a = randBits(32);
    drive(1'b1, 4'hF, 1'b0, a, {4'b0110, 1'b0}, 6'h0, 1'b0); // Status and extension
    expCpsr = {expCpsr[31:24], a[23:8], expCpsr[7:0]};
    checkWord("msrCpsr", "status and extension", expCpsr, cpsr);
    a = randBits(32);
    drive(1'b1, 4'h0, 1'b0, {a[31:8], 8'h0A}, {4'b0001, 1'b0}, 6'h0, 1'b0);
    expCpsr = {expCpsr[31:8], 3'b000, expCpsr.mode}; // Mode 01010 is not legal
    checkWord("msrCpsr", "illegal mode", expCpsr, cpsr);
    drive(1'b1, 4'h0, 1'b0, {a[31:8], 8'h70}, {4'b0001, 1'b0}, 6'h0, 1'b0);
    expCpsr = {expCpsr[31:8], 8'h70}; // Drop to user with Thumb and FIQ mask set
    checkWord("msrCpsr", "enter user", expCpsr, cpsr);
    a = randBits(32);
    drive(1'b1, 4'h0, 1'b0, {a[31:8], 8'hDF}, {4'b1111, 1'b0}, 6'h0, 1'b0);
    expCpsr = {a[31:24], expCpsr[23:0]}; // User reaches only the flags byte
    checkWord("msrCpsr", "user fields", expCpsr, cpsr);
  endtask

  task automatic testExceptions();
    logic [5:0]     lines [6];
    psrPkg::cpuMode modes [6];
    psrPkg::psrWord saved;
    logic [31:0]    r;
    int             i;
    lines = '{6'b111111, 6'b111111, 6'b111011, 6'b111010, 6'b111100, 6'b110000};
    modes = '{psrPkg::modeAbort, psrPkg::modeFiq, psrPkg::modeIrq,
              psrPkg::modeAbort, psrPkg::modeUndef, psrPkg::modeSvc};
    for (i = 0; i < 6; i++) begin
      r = randBits(4);
      drive(1'b1, r[3:0], 1'b0, 32'h0, 5'h0, lines[i], 1'b0);
      saved       = expCpsr;
      saved.flags = r[3:0];
      expCpsr     = entryWord(expCpsr, r[3:0], modes[i]);
      checkWord("exception", "cpsr", expCpsr, cpsr);
      checkWord("exception", "target spsr", saved, spsr);
    end
    drive(1'b1, expCpsr.flags, 1'b0, 32'h0, 5'h0, 6'b010000, 1'b0); // SWI while in svc
    checkWord("exception", "cpsr on re-entry", expCpsr, cpsr);
    checkWord("exception", "spsr on re-entry", saved, spsr);
  endtask

  task automatic testMsrSpsr();
    psrPkg::psrWord sysWord;
    logic [31:0]    r;
    r       = randBits(24);
    sysWord = {r[23:0], 8'h1F}; // System mode, both interrupts open
    drive(1'b1, 4'hF, 1'b0, sysWord, {4'b1111, 1'b1}, 6'h0, 1'b0);
    checkWord("msrSpsr", "cpsr kept", expCpsr, cpsr);
    checkWord("msrSpsr", "svc spsr", sysWord, spsr);
    drive(1'b1, 4'hF, 1'b0, 32'h0, 5'h0, 6'h0, 1'b1);
    expCpsr = sysWord;
    checkWord("msrSpsr", "cpsr after restore", expCpsr, cpsr);
    checkWord("msrSpsr", "system spsr view", expCpsr, spsr);
    r = randBits(4);
    drive(1'b1, r[3:0], 1'b0, ~sysWord, {4'b1111, 1'b1}, 6'h0, 1'b0);
    expCpsr.flags = r[3:0]; // No bank, so only the flag update
    checkWord("msrSpsr", "system msr ignored", expCpsr, cpsr);
    r = randBits(4);
    drive(1'b1, r[3:0], 1'b0, 32'h0, 5'h0, 6'h0, 1'b1);
    expCpsr.flags = r[3:0];
    checkWord("msrSpsr", "system restore ignored", expCpsr, spsr);
  endtask

  task automatic testPrecedence();
    psrPkg::psrWord saved;
    logic [31:0]    r;
    r = randBits(4);
    drive(1'b1, r[3:0], 1'b0, randBits(32), {4'b1111, 1'b0}, 6'b000010, 1'b1);
    saved       = expCpsr;
    saved.flags = r[3:0];
    expCpsr     = entryWord(expCpsr, r[3:0], psrPkg::modeIrq);
    checkWord("precedence", "irq over msr cpsr", expCpsr, cpsr);
    checkWord("precedence", "irq spsr", saved, spsr);
    r = randBits(4);
    drive(1'b1, r[3:0], 1'b0, randBits(32), {4'b1111, 1'b1}, 6'b000001, 1'b1);
    saved       = expCpsr;
    saved.flags = r[3:0];
    expCpsr     = entryWord(expCpsr, r[3:0], psrPkg::modeFiq);
    checkWord("precedence", "fiq over msr spsr", expCpsr, cpsr);
    checkWord("precedence", "fiq spsr", saved, spsr);
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    advance       = 1'b0;
    flagsNext     = 4'h0;
    coprocFlagUpd = 1'b0;
    aluOut        = '0;
    msrReq        = '0;
    exceptions    = '0;
    restore       = 1'b0;
    lfsr          = 16'd61232;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    testReset();
    testFlags();
    testMsrCpsr();
    testExceptions();
    testMsrSpsr();
    testPrecedence();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, u_dut.uSva.failCount);
    if (errors == 0 && u_dut.uSva.failCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
psrPkg.sv
psrReqPkg.sv
exceptPriority.sv
msrMerge.sv
spsrBank.sv
psrControl.sv
psrUnit.sv
psrUnit_sva.sv
psrUnit_tb.sv

/* Bender.yml */
package:
  name: psr_unit

sources:
  - include_dirs:
      - .
    files:
      - psrPkg.sv
      - psrReqPkg.sv
      - exceptPriority.sv
      - msrMerge.sv
      - spsrBank.sv
      - psrControl.sv
      - psrUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - psrUnit_sva.sv
      - psrUnit_tb.sv
